// File: src/fft_pkg.sv
package fft_pkg;

  // ==========================================================================
  // sizes
  // ==========================================================================

  localparam int n_samples    = 8;               // points per frame.
  localparam int log2_n       = 3;               // number of butterfly stages.
  localparam int n_twiddles   = n_samples / 2;   // k = 0..3.
  localparam int sample_width = 32;              // one re or im value.
  localparam int frac_bits    = 16;              // q16.16.
  localparam int prod_width   = 2 * sample_width;

  // ==========================================================================
  // fixed-point types
  // ==========================================================================

  typedef logic signed [sample_width-1:0] sample_t;
  typedef logic signed [prod_width-1:0]   prod_t;
  typedef logic        [1:0]              stage_idx_t;

  typedef struct packed {
    sample_t re;
    sample_t im;
  } cplx_t;

  // w^k = cos - j*sin.
  typedef struct packed {
    sample_t cos;
    sample_t sin;
  } twiddle_t;

  // ==========================================================================
  // frames
  // ==========================================================================

  typedef sample_t  [n_samples-1:0]  real_frame_t;     // index 0 is first sample.
  typedef cplx_t    [n_samples-1:0]  cplx_frame_t;     // index k is bin k.
  typedef twiddle_t [n_twiddles-1:0] twiddle_table_t;

  // ==========================================================================
  // twiddle constants
  // ==========================================================================

  // round(value * 65536).
  localparam sample_t tw_one        = sample_t'(1 << frac_bits);
  localparam sample_t tw_half_sqrt2 = sample_t'(46341);   // 0.70710678 * 65536.

endpackage

// File: src/twiddle_rom.sv
module twiddle_rom import fft_pkg::*; (
  output twiddle_table_t twiddles
);

  // ==========================================================================
  // w^k for k = 0..3, angles 0, 45, 90 and 135 degrees
  // ==========================================================================

  // cos falls from one to minus root-half over the half turn,
  // sin stays non-negative so only its magnitude changes.
  always_comb begin
    for (int k = 0; k < n_twiddles; k++) begin
      case (k)
        0: begin
          twiddles[k].cos = tw_one;          // w^0 = 1.
          twiddles[k].sin = '0;
        end
        1: begin
          twiddles[k].cos = tw_half_sqrt2;
          twiddles[k].sin = tw_half_sqrt2;
        end
        2: begin
          twiddles[k].cos = '0;              // w^2 = -j.
          twiddles[k].sin = tw_one;
        end
        default: begin
          twiddles[k].cos = -tw_half_sqrt2;  // second quadrant.
          twiddles[k].sin = tw_half_sqrt2;
        end
      endcase
    end
  end

endmodule

// File: src/butterfly.sv
module butterfly import fft_pkg::*; (
  input  cplx_t    a,
  input  cplx_t    b,
  input  twiddle_t w,
  output cplx_t    sum,
  output cplx_t    diff
);

  // ==========================================================================
  // twiddle multiply, t = b * (cos - j*sin)
  // ==========================================================================

  prod_t   p_re_cos;
  prod_t   p_im_sin;
  prod_t   p_im_cos;
  prod_t   p_re_sin;
  sample_t s_re_cos;
  sample_t s_im_sin;
  sample_t s_im_cos;
  sample_t s_re_sin;
  cplx_t   t;

  // full width products, sign extended first.
  assign p_re_cos = prod_t'(b.re) * prod_t'(w.cos);
  assign p_im_sin = prod_t'(b.im) * prod_t'(w.sin);
  assign p_im_cos = prod_t'(b.im) * prod_t'(w.cos);
  assign p_re_sin = prod_t'(b.re) * prod_t'(w.sin);

  // back to q16.16, rounds toward minus infinity.
  assign s_re_cos = sample_t'(p_re_cos >>> frac_bits);
  assign s_im_sin = sample_t'(p_im_sin >>> frac_bits);
  assign s_im_cos = sample_t'(p_im_cos >>> frac_bits);
  assign s_re_sin = sample_t'(p_re_sin >>> frac_bits);

  // (re + j*im)(cos - j*sin).
  assign t.re = s_re_cos + s_im_sin;
  assign t.im = s_im_cos - s_re_sin;

  // ==========================================================================
  // radix-2 outputs, wrap at 32 bits
  // ==========================================================================

  assign sum.re  = a.re + t.re;
  assign sum.im  = a.im + t.im;
  assign diff.re = a.re - t.re;
  assign diff.im = a.im - t.im;

endmodule

// File: src/fft_stage.sv
module fft_stage import fft_pkg::*; #(
  parameter stage_idx_t stage = 2'd0
) (
  input  logic           clk,
  input  logic           rst_n,

  input  cplx_frame_t    recv_msg,
  input  logic           recv_val,
  output logic           recv_rdy,

  output cplx_frame_t    send_msg,
  output logic           send_val,
  input  logic           send_rdy,

  input  twiddle_table_t twiddles
);

  // distance between paired elements, group is twice this.
  localparam int span    = 1 << stage;
  localparam int tw_step = n_twiddles >> stage;

  cplx_frame_t bfly_frame;
  cplx_frame_t frame_q;
  logic        full_q;
  logic        load;

  // ==========================================================================
  // butterflies
  // ==========================================================================

  // butterfly i works on element j of group g, with g = i / span
  // and j = i % span. pairing is fixed at elaboration.
  for (genvar i = 0; i < n_samples / 2; i++) begin : g_bfly
    localparam int j      = i % span;
    localparam int top    = (i / span) * 2 * span + j;
    localparam int bot    = top + span;
    localparam int tw_idx = j * tw_step;

    butterfly u_bfly (
      .a    (recv_msg[top]),
      .b    (recv_msg[bot]),
      .w    (twiddles[tw_idx]),
      .sum  (bfly_frame[top]),
      .diff (bfly_frame[bot])
    );
  end

  // ==========================================================================
  // stage buffer
  // ==========================================================================

  // take a new frame when empty or when the held one leaves now.
  assign recv_rdy = !full_q || send_rdy;
  assign load     = recv_val && recv_rdy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (recv_rdy) begin
      full_q <= recv_val;  // refill or drain.
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      frame_q <= bfly_frame;
    end
  end

  assign send_msg = frame_q;
  assign send_val = full_q;

endmodule

// File: src/fft.sv
module fft import fft_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  input  real_frame_t recv_msg,
  input  logic        recv_val,
  output logic        recv_rdy,

  output cplx_frame_t send_msg,
  output logic        send_val,
  input  logic        send_rdy
);

  // mirror the low log2_n bits of an index.
  function automatic int bit_rev(input int idx);
    int rev;
    rev = 0;
    for (int b = 0; b < log2_n; b++) begin
      rev = (rev << 1) | ((idx >> b) & 1);
    end
    return rev;
  endfunction

  cplx_frame_t    in_frame;
  cplx_frame_t    chain_msg [log2_n+1];
  logic           chain_val [log2_n+1];
  logic           chain_rdy [log2_n+1];
  twiddle_table_t twiddles;

  // ==========================================================================
  // input reorder
  // ==========================================================================

  // real input only, so every im starts at zero.
  for (genvar i = 0; i < n_samples; i++) begin : g_reorder
    assign in_frame[i].re = recv_msg[bit_rev(i)];
    assign in_frame[i].im = '0;
  end

  assign chain_msg[0] = in_frame;
  assign chain_val[0] = recv_val;
  assign recv_rdy     = chain_rdy[0];

  // ==========================================================================
  // stage chain
  // ==========================================================================

  twiddle_rom u_twiddle_rom (
    .twiddles (twiddles)
  );

  for (genvar s = 0; s < log2_n; s++) begin : g_stage
    fft_stage #(
      .stage (stage_idx_t'(s))
    ) u_stage (
      .clk      (clk),
      .rst_n    (rst_n),
      .recv_msg (chain_msg[s]),
      .recv_val (chain_val[s]),
      .recv_rdy (chain_rdy[s]),
      .send_msg (chain_msg[s+1]),
      .send_val (chain_val[s+1]),
      .send_rdy (chain_rdy[s+1]),
      .twiddles (twiddles)
    );
  end

  assign send_msg          = chain_msg[log2_n];
  assign send_val          = chain_val[log2_n];
  assign chain_rdy[log2_n] = send_rdy;  // consumer back-pressure.

endmodule

// File: testbench/fft_tb.sv
module fft_tb import fft_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          timeout_cycles = 1000;
  localparam int          n_random       = 200;
  localparam int          n_stream       = 20;
  localparam logic [31:0] seed           = 32'hae646150;
  localparam real         pi             = 3.14159265358979;

  typedef enum {rdy_high, rdy_random, rdy_low} rdy_mode_t;

  logic        clk;
  logic        rst_n;
  real_frame_t recv_msg;
  logic        recv_val;
  logic        recv_rdy;
  cplx_frame_t send_msg;
  logic        send_val;
  logic        send_rdy;

  logic [31:0] data_rng;
  logic [31:0] rdy_rng;
  rdy_mode_t   rdy_mode;
  rdy_mode_t   sink_mode;
  logic        check_latency;

  cplx_frame_t exp_q [$];   // expected outputs in arrival order.
  int          acc_q [$];   // accepting cycle of each expected frame.
  int          cycle_cnt;
  int          in_count;
  int          out_count;
  logic        hold_pending;
  cplx_frame_t held_msg;
  cplx_frame_t exp_frame;
  int          acc_cycle;

  fft u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .recv_msg (recv_msg),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .send_msg (send_msg),
    .send_val (send_val),
    .send_rdy (send_rdy)
  );

  always #50 clk = ~clk;

  // ==========================================================================
  // random source and reference model
  // ==========================================================================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_random();
    data_rng = xorshift32(data_rng);
    return data_rng;
  endfunction

  // uniform over -8.0 .. +8.0.
  function automatic sample_t rand_sample();
    logic [31:0] r;
    r = next_random();
    return sample_t'(int'(r % 32'd1048577) - 524288);
  endfunction

  function automatic real_frame_t rand_frame();
    real_frame_t f;
    for (int i = 0; i < n_samples; i++) begin
      f[i] = rand_sample();
    end
    return f;
  endfunction

  function automatic sample_t round_q16(input real v);
    return sample_t'($rtoi($floor(v * 65536.0 + 0.5)));
  endfunction

  // full product floored back to q16.16.
  function automatic int mul_q16(input int a, input int b);
    longint p;
    p = longint'(a) * longint'(b);
    return int'(p >>> frac_bits);
  endfunction

  function automatic cplx_frame_t fft_model(input real_frame_t x);
    int          re [n_samples];
    int          im [n_samples];
    int          w_cos [n_samples/2];
    int          w_sin [n_samples/2];
    int          rev;
    int          half;
    int          k;
    int          top;
    int          bot;
    int          t_re;
    int          t_im;
    cplx_frame_t y;
    // w^k = cos(2 pi k / n) - j sin(2 pi k / n).
    for (int i = 0; i < n_samples / 2; i++) begin
      w_cos[i] = round_q16($cos(2.0 * pi * i / n_samples));
      w_sin[i] = round_q16($sin(2.0 * pi * i / n_samples));
    end
    for (int i = 0; i < n_samples; i++) begin
      rev = 0;
      for (int b = 0; b < log2_n; b++) begin
        if (((i >> b) & 1) != 0) begin
          rev = rev | (1 << (log2_n - 1 - b));
        end
      end
      re[i] = x[rev];
      im[i] = 0;
    end
    // sub-transform size m doubles each pass.
    for (int m = 2; m <= n_samples; m = m * 2) begin
      half = m / 2;
      for (int g = 0; g < n_samples; g += m) begin
        for (int j = 0; j < half; j++) begin
          k       = j * (n_samples / m);
          top     = g + j;
          bot     = top + half;
          t_re    = mul_q16(re[bot], w_cos[k]) + mul_q16(im[bot], w_sin[k]);
          t_im    = mul_q16(im[bot], w_cos[k]) - mul_q16(re[bot], w_sin[k]);
          re[bot] = re[top] - t_re;
          im[bot] = im[top] - t_im;
          re[top] = re[top] + t_re;
          im[top] = im[top] + t_im;
        end
      end
    end
    for (int i = 0; i < n_samples; i++) begin
      y[i].re = sample_t'(re[i]);
      y[i].im = sample_t'(im[i]);
    end
    return y;
  endfunction

  // ==========================================================================
  // checks
  // ==========================================================================

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_frame(input cplx_frame_t got, input cplx_frame_t exp);
    for (int k = 0; k < n_samples; k++) begin
      if (got[k].re !== exp[k].re) begin
        fail_run($sformatf("ERROR %0t send_msg[%0d].re got %0d exp %0d",
                           $time, k, got[k].re, exp[k].re));
      end
      if (got[k].im !== exp[k].im) begin
        fail_run($sformatf("ERROR %0t send_msg[%0d].im got %0d exp %0d",
                           $time, k, got[k].im, exp[k].im));
      end
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR %0t %s got %b exp %b", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      fail_run($sformatf("ERROR %0t %s got %0d exp %0d", $time, name, got, exp));
    end
  endtask

  // ==========================================================================
  // driver tasks return 1 ns after a rising edge
  // ==========================================================================

  task automatic offer_frame(input real_frame_t f, output int waited);
    waited   = 0;
    recv_msg = f;
    recv_val = 1'b1;
    do begin
      @(posedge clk);
      waited++;
      if (waited > timeout_cycles) begin
        fail_run("timed out waiting for recv_rdy");
      end
    end while (!recv_rdy);
    #1;
  endtask

  task automatic idle_cycles(input int n);
    recv_val = 1'b0;
    repeat (n) @(posedge clk);
    if (n > 0) begin
      #1;
    end
  endtask

  task automatic wait_send_val();
    int waited;
    waited = 0;
    while (!send_val) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > timeout_cycles) begin
        fail_run("timed out waiting for send_val");
      end
    end
  endtask

  // empty once send_val stays low for as many cycles as there are stages.
  task automatic wait_drain();
    int waited;
    int quiet;
    waited = 0;
    quiet  = 0;
    while (quiet < log2_n) begin
      @(posedge clk);
      #1;
      waited++;
      if (send_val) begin
        quiet = 0;
      end else begin
        quiet++;
      end
      if (waited > timeout_cycles) begin
        fail_run("timed out waiting for the pipeline to drain");
      end
    end
  endtask

  task automatic run_directed(input real_frame_t f, input cplx_frame_t exp);
    int waited;
    offer_frame(f, waited);
    idle_cycles(0);
    wait_send_val();
    check_frame(send_msg, exp);
    wait_drain();
  endtask

  // ==========================================================================
  // consumer and scoreboard
  // ==========================================================================

  always @(posedge clk) begin
    sink_mode = rdy_mode;
    #1;
    rdy_rng = xorshift32(rdy_rng);
    case (sink_mode)
      rdy_high: send_rdy = 1'b1;
      rdy_low:  send_rdy = 1'b0;
      default:  send_rdy = (rdy_rng[1:0] != 2'b00);   // ready 3 of 4.
    endcase
  end

  always @(posedge clk) begin
    if (rst_n) begin
      cycle_cnt++;
      if (hold_pending) begin
        check_bit("send_val", send_val, 1'b1);   // stalled frame must stay.
        check_frame(send_msg, held_msg);
      end
      if (send_val && send_rdy) begin
        if (exp_q.size() == 0) begin
          fail_run("output frame arrived with none expected");
        end else begin
          exp_frame = exp_q.pop_front();
          acc_cycle = acc_q.pop_front();
          check_frame(send_msg, exp_frame);
          if (check_latency) begin
            check_count("latency", cycle_cnt - acc_cycle, 3);
          end
          out_count++;
        end
      end
      hold_pending = send_val && !send_rdy;
      held_msg     = send_msg;
      if (recv_val && recv_rdy) begin
        exp_q.push_back(fft_model(recv_msg));
        acc_q.push_back(cycle_cnt);
        in_count++;
      end
    end
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================

  initial begin : stimulus
    real_frame_t frame;
    cplx_frame_t expect_frame;
    int          waited;
    int          gap;

    clk           = 1'b0;
    rst_n         = 1'b0;
    recv_val      = 1'b0;
    recv_msg      = '0;
    send_rdy      = 1'b1;
    data_rng      = seed;
    rdy_rng       = ~seed;
    rdy_mode      = rdy_high;
    sink_mode     = rdy_high;
    check_latency = 1'b0;
    cycle_cnt     = 0;
    in_count      = 0;
    out_count     = 0;
    hold_pending  = 1'b0;

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_bit("send_val", send_val, 1'b0);
    check_bit("recv_rdy", recv_rdy, 1'b1);

    // impulse gives a flat spectrum.
    frame    = '0;
    frame[0] = sample_t'(65536);
    for (int k = 0; k < n_samples; k++) begin
      expect_frame[k].re = sample_t'(65536);
      expect_frame[k].im = '0;
    end
    run_directed(frame, expect_frame);

    // constant 1.5 puts all energy in bin 0.
    for (int i = 0; i < n_samples; i++) begin
      frame[i] = sample_t'(98304);
    end
    expect_frame       = '0;
    expect_frame[0].re = sample_t'(8 * 98304);
    run_directed(frame, expect_frame);

    rdy_mode = rdy_random;
    for (int i = 0; i < n_random; i++) begin
      gap = int'(next_random() % 32'd3);
      if (gap != 0) begin
        idle_cycles(gap);
      end
      offer_frame(rand_frame(), waited);
    end
    idle_cycles(0);
    rdy_mode = rdy_high;
    wait_drain();
    check_count("frames out", out_count, in_count);

    // ========================================================================
    // back-pressure fills the three stages from the back
    // ========================================================================

    rdy_mode = rdy_low;
    idle_cycles(2);
    recv_msg = rand_frame();
    recv_val = 1'b1;
    for (int i = 0; i < log2_n; i++) begin
      @(posedge clk);
      check_bit("recv_rdy", recv_rdy, 1'b1);
      #1;
      recv_msg = rand_frame();
    end
    repeat (6) begin
      @(posedge clk);
      check_bit("recv_rdy", recv_rdy, 1'b0);
    end
    #1;
    rdy_mode = rdy_high;
    offer_frame(recv_msg, waited);   // fourth frame still on offer.
    idle_cycles(0);
    wait_drain();
    check_count("frames out", out_count, in_count);

    // full rate with one frame per edge.
    check_latency = 1'b1;
    for (int i = 0; i < n_stream; i++) begin
      offer_frame(rand_frame(), waited);
      check_count("recv_rdy wait cycles", waited, 1);
    end
    idle_cycles(0);
    wait_drain();
    check_latency = 1'b0;

    if (exp_q.size() != 0) begin
      fail_run("frames left in the scoreboard at the end");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

// File: project.f
src/fft_pkg.sv
src/twiddle_rom.sv
src/butterfly.sv
src/fft_stage.sv
src/fft.sv
testbench/fft_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := fft_tb
FILELIST   := project.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Done: no errors
FLAGS      := --binary --timing --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail, not the exit code of the model
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
